/* source/fetch_fifo.sv */
`default_nettype none

module fetch_fifo (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic                                  flush_i,  // Drop all entries
  input  logic                                  push_i,
  input  prefetch_pkg::fetch_entry_t            entry_i,
  input  logic                                  pop_i,
  output prefetch_pkg::fetch_entry_t            entry_o,  // Head entry
  output logic [prefetch_pkg::cnt_width_lp-1:0] count_o,
  output logic                                  empty_o
);

  import prefetch_pkg::*;

  typedef logic [cnt_width_lp-2:0] ptr_t;

  fetch_entry_t            mem_q [fifo_depth_lp];  // Storage, no reset
  ptr_t                    wr_ptr_q;
  ptr_t                    rd_ptr_q;
  logic [cnt_width_lp-1:0] count_q;  // Occupancy
  logic                    do_push;
  logic                    do_pop;

  // Circular increment, works for any depth
  function automatic ptr_t ptr_next(input ptr_t ptr);
    ptr_next = (ptr == ptr_t'(fifo_depth_lp - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Flush wins over push and pop
  assign do_push = push_i & ~flush_i & (count_q != cnt_width_lp'(fifo_depth_lp));
  assign do_pop  = pop_i & ~flush_i & ~empty_o;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;  // Empty in one cycle
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  assign entry_o = mem_q[rd_ptr_q];
  assign count_o = count_q;  // Feeds the credit rule
  assign empty_o = (count_q == '0);

endmodule

`default_nettype wire

/* source/obi_instr_port.sv */
`default_nettype none

module obi_instr_port (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  prefetch_pkg::bus_req_t trans_i,        // Transaction wish from controller
  output logic                   trans_ready_o,  // Address phase granted
  output prefetch_pkg::bus_rsp_t rsp_o,          // Response beat
  output logic                   instr_req_o,
  input  logic                   instr_gnt_i,
  output logic [31:0]            instr_addr_o,
  input  logic [31:0]            instr_rdata_i,
  input  logic                   instr_rvalid_i,
  input  logic                   instr_err_i
);

  typedef enum logic {PORT_IDLE, PORT_WAIT} port_state_e;

  port_state_e state_q;
  port_state_e state_d;
  logic [31:0] addr_q;  // Address held while grant is pending

  // Address phase FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      PORT_IDLE: begin
        if (trans_i.valid && !instr_gnt_i) begin
          state_d = PORT_WAIT;  // Not granted, freeze the address
        end
      end
      PORT_WAIT: begin
        if (instr_gnt_i) begin
          state_d = PORT_IDLE;
        end
      end
      default: state_d = PORT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= PORT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture on the first request cycle only
  always_ff @(posedge clk) begin
    if (state_q == PORT_IDLE && trans_i.valid) begin
      addr_q <= trans_i.addr;
    end
  end

  // Once raised, req stays up until gnt, independent of the controller
  assign instr_req_o   = (state_q == PORT_WAIT) | trans_i.valid;
  assign instr_addr_o  = (state_q == PORT_WAIT) ? addr_q : trans_i.addr;
  assign trans_ready_o = instr_req_o & instr_gnt_i;

  // Data phase is forwarded untouched
  assign rsp_o = '{valid: instr_rvalid_i, rdata: instr_rdata_i, err: instr_err_i};

endmodule

`default_nettype wire

/* source/outstanding_counter.sv */
`default_nettype none

module outstanding_counter (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic                                  issue_i,   // Request granted
  input  logic                                  retire_i,  // Response seen
  input  logic                                  branch_i,  // Everything in flight goes stale
  output logic [prefetch_pkg::cnt_width_lp-1:0] outstanding_o,
  output logic                                  discard_o
);

  import prefetch_pkg::*;

  logic [cnt_width_lp-1:0] out_q;
  logic [cnt_width_lp-1:0] out_d;
  logic [cnt_width_lp-1:0] discard_q;  // Stale responses still to come
  logic [cnt_width_lp-1:0] discard_d;

  always_comb begin
    out_d = out_q;
    if (issue_i)  out_d = out_d + 1'b1;
    if (retire_i) out_d = out_d - 1'b1;
  end

  // Stale count takes everything that will still be in flight next cycle,
  // a grant landing in the branch cycle included
  always_comb begin
    discard_d = discard_q;
    if (branch_i) begin
      discard_d = out_d;
    end else if (retire_i && discard_q != '0) begin
      discard_d = discard_q - 1'b1;  // Retire eats stale ones first
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      discard_q <= '0;
    end else begin
      out_q     <= out_d;
      discard_q <= discard_d;
    end
  end

  assign outstanding_o = out_q;
  assign discard_o     = (discard_q != '0);

endmodule

`default_nettype wire

/* source/prefetch_buffer.sv */
`default_nettype none

module prefetch_buffer (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       req_i,
  input  logic                       branch_i,
  input  logic [31:0]                branch_addr_i,
  input  logic                       fetch_ready_i,
  output logic                       fetch_valid_o,
  output prefetch_pkg::fetch_entry_t fetch_entry_o,
  output logic                       instr_req_o,
  input  logic                       instr_gnt_i,
  output logic [31:0]                instr_addr_o,
  input  logic [31:0]                instr_rdata_i,
  input  logic                       instr_rvalid_i,
  input  logic                       instr_err_i,
  output logic                       busy_o
);

  import prefetch_pkg::*;

  bus_req_t                trans;
  logic                    trans_ready;
  bus_rsp_t                rsp;
  logic [31:0]             rsp_addr;
  logic [cnt_width_lp-1:0] outstanding;
  logic                    discard;
  logic                    issue;
  logic                    retire;
  logic                    sel_fifo;
  logic                    fifo_push;
  logic                    fifo_pop;
  logic                    fifo_flush;
  logic [cnt_width_lp-1:0] fifo_count;
  logic                    fifo_empty;
  fetch_entry_t            fifo_head;
  fetch_entry_t            live_entry;  // Tagged response of this cycle

  //////////////////////////////
  // Bus side
  //////////////////////////////

  obi_instr_port u_port (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .trans_i       (trans),
    .trans_ready_o (trans_ready),
    .rsp_o         (rsp),
    .instr_req_o   (instr_req_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_addr_o  (instr_addr_o),
    .instr_rdata_i (instr_rdata_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_err_i   (instr_err_i)
  );

  // Flush doubles as the branch event
  outstanding_counter u_cnt (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .issue_i      (issue),
    .retire_i     (retire),
    .branch_i     (fifo_flush),
    .outstanding_o(outstanding),
    .discard_o    (discard)
  );

  //////////////////////////////
  // FIFO and fall-through
  //////////////////////////////

  assign live_entry = '{addr: rsp_addr, rdata: rsp.rdata, err: rsp.err};

  fetch_fifo u_fifo (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .flush_i(fifo_flush),
    .push_i (fifo_push),
    .entry_i(live_entry),
    .pop_i  (fifo_pop),
    .entry_o(fifo_head),
    .count_o(fifo_count),
    .empty_o(fifo_empty)
  );

  // Empty FIFO lets the response through in the same cycle
  assign fetch_entry_o = sel_fifo ? fifo_head : live_entry;

  prefetch_controller u_ctrl (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .branch_i     (branch_i),
    .branch_addr_i(branch_addr_i),
    .busy_o       (busy_o),
    .trans_o      (trans),
    .trans_ready_i(trans_ready),
    .rsp_i        (rsp),
    .rsp_addr_o   (rsp_addr),
    .outstanding_i(outstanding),
    .discard_i    (discard),
    .issue_o      (issue),
    .retire_o     (retire),
    .fetch_ready_i(fetch_ready_i),
    .fetch_valid_o(fetch_valid_o),
    .sel_fifo_o   (sel_fifo),
    .push_o       (fifo_push),
    .pop_o        (fifo_pop),
    .flush_o      (fifo_flush),
    .fifo_count_i (fifo_count),
    .fifo_empty_i (fifo_empty)
  );

endmodule

`default_nettype wire

/* source/prefetch_controller.sv */
`default_nettype none

module prefetch_controller (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic                                  req_i,
  input  logic                                  branch_i,
  input  logic [31:0]                           branch_addr_i,
  output logic                                  busy_o,
  output prefetch_pkg::bus_req_t                trans_o,
  input  logic                                  trans_ready_i,  // Grant
  input  prefetch_pkg::bus_rsp_t                rsp_i,
  output logic [31:0]                           rsp_addr_o,     // Tag for the live response
  input  logic [prefetch_pkg::cnt_width_lp-1:0] outstanding_i,
  input  logic                                  discard_i,
  output logic                                  issue_o,
  output logic                                  retire_o,
  input  logic                                  fetch_ready_i,
  output logic                                  fetch_valid_o,
  output logic                                  sel_fifo_o,
  output logic                                  push_o,
  output logic                                  pop_o,
  output logic                                  flush_o,
  input  logic [prefetch_pkg::cnt_width_lp-1:0] fifo_count_i,
  input  logic                                  fifo_empty_i
);

  import prefetch_pkg::*;

  typedef enum logic [1:0] {IDLE, FETCH, BRANCH_WAIT} ctrl_state_e;

  ctrl_state_e           state_q;
  ctrl_state_e           state_d;
  logic [31:0]           fetch_addr_q;  // Next address to ask for
  logic [31:0]           tag_addr_q;    // Oldest live request
  logic [31:0]           target;        // Branch target, word aligned
  logic                  pending_q;     // Request up, no grant yet
  logic                  wait_gnt;
  logic [cnt_width_lp:0] credit_sum;
  logic                  credit_ok;
  logic                  new_req;
  logic                  rsp_live;      // Response for the current stream

  assign target     = {branch_addr_i[31:2], 2'b00};
  assign wait_gnt   = pending_q & ~trans_ready_i;
  // Buffered plus in flight must stay below depth, so a push always fits
  assign credit_sum = {1'b0, fifo_count_i} + {1'b0, outstanding_i};
  assign credit_ok  = credit_sum < (cnt_width_lp + 1)'(fifo_depth_lp);

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, FETCH: begin
        if (branch_i) begin
          state_d = wait_gnt ? BRANCH_WAIT : FETCH;  // Old address still on the bus
        end else if (state_q == IDLE && req_i) begin
          state_d = FETCH;
        end else if (!req_i) begin
          state_d = IDLE;
        end
      end
      BRANCH_WAIT: begin
        if (trans_ready_i) state_d = FETCH;  // Stale grant done, target next
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= IDLE;
      pending_q    <= 1'b0;
      fetch_addr_q <= '0;
      tag_addr_q   <= '0;
    end else begin
      state_q   <= state_d;
      pending_q <= trans_o.valid & ~trans_ready_i;
      if (branch_i) begin
        fetch_addr_q <= target;
        tag_addr_q   <= target;
      end else begin
        if (issue_o && state_q != BRANCH_WAIT) fetch_addr_q <= fetch_addr_q + 32'd4;
        if (rsp_live) tag_addr_q <= tag_addr_q + 32'd4;  // In-order responses
      end
    end
  end

  // A raised request is held until granted
  assign new_req = (state_q == FETCH) & req_i & credit_ok & ~branch_i;
  assign trans_o = '{valid: pending_q | new_req, addr: fetch_addr_q};
  assign issue_o = trans_o.valid & trans_ready_i;
  // Second flush marks the stale grant as discardable
  assign flush_o = branch_i | ((state_q == BRANCH_WAIT) & trans_ready_i);

  //////////////////////////////
  // Response steering
  //////////////////////////////

  assign retire_o      = rsp_i.valid;
  assign rsp_live      = rsp_i.valid & ~discard_i;
  assign rsp_addr_o    = tag_addr_q;
  assign sel_fifo_o    = ~fifo_empty_i;  // FIFO head is older than any live beat
  assign fetch_valid_o = ~fifo_empty_i | rsp_live;
  assign pop_o         = ~fifo_empty_i & fetch_ready_i & ~branch_i;
  // Push unless the beat falls straight through
  assign push_o        = rsp_live & ~branch_i & ~(fifo_empty_i & fetch_ready_i);
  assign busy_o        = trans_o.valid | (outstanding_i != '0);

endmodule

`default_nettype wire

/* source/prefetch_pkg.sv */
`default_nettype none

package prefetch_pkg;

  //////////////////////////////
  // Sizing
  //////////////////////////////

  // FIFO depth, must stay >= 2
  localparam int fifo_depth_lp = 4;
  // Counts run 0..fifo_depth_lp inclusive
  localparam int cnt_width_lp  = $clog2(fifo_depth_lp) + 1;

  //////////////////////////////
  // Transfer types
  //////////////////////////////

  // Address phase wish, controller -> bus port
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;   // Word aligned
  } bus_req_t;

  // Data phase beat, bus port -> controller
  typedef struct packed {
    logic        valid;  // Mirrors rvalid
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

  // One fetched word with its tag, 65 bits
  typedef struct packed {
    logic [31:0] addr;   // Address the word came from
    logic [31:0] rdata;
    logic        err;    // Bus error on this word
  } fetch_entry_t;

endpackage

`default_nettype wire

/* sources.f */
source/prefetch_pkg.sv
source/obi_instr_port.sv
source/fetch_fifo.sv
source/outstanding_counter.sv
source/prefetch_controller.sv
source/prefetch_buffer.sv
testbench/instr_mem_model.sv
testbench/prefetch_buffer_props.sv
testbench/tb_prefetch_buffer.sv

/* testbench/instr_mem_model.sv */
`default_nettype none

module instr_mem_model (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic [1:0]  rand_i,      // Fresh random bits every cycle
  input  logic [31:0] err_addr_i,  // Word that answers with a bus error
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rsp_addr_o,  // Address of the word in the data phase
  output logic        err_o
);

  logic [31:0] pend_q[$];  // Granted but not yet answered, oldest first

  // Grant about half of the request cycles
  assign gnt_o = req_i & rand_i[0];

  always @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q.delete();
      rvalid_o   <= 1'b0;
      rsp_addr_o <= '0;
      err_o      <= 1'b0;
    end else begin
      if (req_i && gnt_o) pend_q.push_back(addr_i);  // One entry per grant
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
      // Earliest answer is the cycle after the grant, in request order
      if (pend_q.size() != 0 && rand_i[1]) begin
        rvalid_o   <= 1'b1;
        rsp_addr_o <= pend_q[0];
        err_o      <= (pend_q[0] == err_addr_i);
        void'(pend_q.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/prefetch_buffer_props.sv */
`default_nettype none

module prefetch_buffer_props (
  input logic                                  clk,
  input logic                                  rst_n_i,
  input logic                                  instr_req_i,
  input logic                                  instr_gnt_i,
  input logic [31:0]                           instr_addr_i,
  input logic                                  fetch_valid_i,
  input logic                                  busy_i,
  input logic [prefetch_pkg::cnt_width_lp-1:0] fifo_count_i,
  input logic                                  fifo_empty_i,
  input logic [prefetch_pkg::cnt_width_lp-1:0] outstanding_i
);

  import prefetch_pkg::*;

  int unsigned fail_count;  // Assertion failures so far

  initial fail_count = 0;

  // Address phase is held until granted
  addr_stable_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else begin
      fail_count++;
      $error("bus request dropped or address moved before its grant");
    end

  // Buffered plus in flight never exceeds the depth, so every push fits
  fifo_bound_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    ({1'b0, fifo_count_i} + {1'b0, outstanding_i}) <= (cnt_width_lp + 1)'(fifo_depth_lp))
    else begin
      fail_count++;
      $error("FIFO count plus requests in flight above depth");
    end

  // A word can only come from the FIFO or from a request in flight
  valid_source_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(fetch_valid_i && !busy_i && fifo_empty_i))
    else begin
      fail_count++;
      $error("fetch_valid_o high with nothing buffered or in flight");
    end

endmodule

bind prefetch_buffer prefetch_buffer_props u_props (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .instr_req_i  (instr_req_o),
  .instr_gnt_i  (instr_gnt_i),
  .instr_addr_i (instr_addr_o),
  .fetch_valid_i(fetch_valid_o),
  .busy_i       (busy_o),
  .fifo_count_i (fifo_count),
  .fifo_empty_i (fifo_empty),
  .outstanding_i(outstanding)
);

`default_nettype wire

/* testbench/tb_prefetch_buffer.sv */
`default_nettype none

module tb_prefetch_buffer;

  import prefetch_pkg::*;

  logic         clk;
  logic         rst_n_i;
  logic         req_i;
  logic         branch_i;
  logic [31:0]  branch_addr_i;
  logic         fetch_ready_i;
  logic         fetch_valid_o;
  fetch_entry_t fetch_entry_o;
  logic         instr_req_o;
  logic         instr_gnt_i;
  logic [31:0]  instr_addr_o;
  logic [31:0]  instr_rdata_i;
  logic         instr_rvalid_i;
  logic         instr_err_i;
  logic         busy_o;

  logic [31:0]  lfsr_q;         // Shared random source
  logic [1:0]   mem_rand;       // Grant and response coin flips
  logic         ready_rand_en;  // Random back-pressure when set
  logic [31:0]  err_addr;
  logic [31:0]  mem_rsp_addr;

  logic [31:0]  exp_addr;       // Next address the core should see
  logic [31:0]  stream_base;    // Target of the last branch
  int           accepted;
  int           live_grants;    // Grants of the current stream
  int           live_accepts;
  int           in_flight;      // Bus grants minus bus responses
  int           err_seen;
  int           checks;
  int           errors;
  int           tests;
  logic         timed_out;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Expected memory word, a fixed mix of the address bits
  function automatic logic [31:0] instr_word(input logic [31:0] addr);
    instr_word = {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic finish_test(input string name);
    tests++;
    if (timed_out) $display("Test %0d %s: skipped after timeout", tests, name);
    else $display("Test %0d %s: done, %0d errors so far", tests, name, errors);
  endtask

  // Waits until the core has taken more words
  task automatic wait_accepts(input int more, input int limit, input string what);
    int goal;
    int n;
    n = 0;
    @(negedge clk);
    goal = accepted + more;
    while (accepted < goal && n < limit && !timed_out) begin
      @(negedge clk);
      n++;
    end
    if (accepted < goal && !timed_out) begin
      timed_out = 1'b1;
      $display("Timeout: %s got only %0d of %0d words", what, more - (goal - accepted), more);
    end
  endtask

  //////////////////////////////
  // DUT and memory
  //////////////////////////////

  always #10 clk = ~clk;

  prefetch_buffer u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .fetch_ready_i (fetch_ready_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_entry_o (fetch_entry_o),
    .instr_req_o   (instr_req_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_addr_o  (instr_addr_o),
    .instr_rdata_i (instr_rdata_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_err_i   (instr_err_i),
    .busy_o        (busy_o)
  );

  instr_mem_model u_mem (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .rand_i    (mem_rand),
    .err_addr_i(err_addr),
    .req_i     (instr_req_o),
    .addr_i    (instr_addr_o),
    .gnt_o     (instr_gnt_i),
    .rvalid_o  (instr_rvalid_i),
    .rsp_addr_o(mem_rsp_addr),
    .err_o     (instr_err_i)
  );

  assign instr_rdata_i = instr_word(mem_rsp_addr);

  // One LFSR step per bit taken
  always @(posedge clk) begin
    logic [2:0]  bits;
    logic [31:0] s;
    s = lfsr_q;
    for (int i = 0; i < 3; i++) begin
      bits[i] = s[0];
      s       = lfsr_next(s);
    end
    lfsr_q        <= s;
    mem_rand      <= bits[1:0];
    fetch_ready_i <= ready_rand_en ? bits[2] : 1'b1;
  end

  //////////////////////////////
  // Comparing process
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_n_i) begin
      if (branch_i) begin  // Branch wins, offered word not taken
        exp_addr     = branch_addr_i & 32'hffff_fffc;
        stream_base  = exp_addr;
        live_grants  = 0;
        live_accepts = 0;
      end else if (fetch_valid_o && fetch_ready_i) begin
        checks++;
        if (fetch_entry_o.addr !== exp_addr) begin
          errors++;
          $display("Fail at %0t: addr %h, expected %h", $time, fetch_entry_o.addr, exp_addr);
        end
        if (fetch_entry_o.rdata !== instr_word(exp_addr)) begin
          errors++;
          $display("Fail at %0t: rdata %h at %h, expected %h", $time,
                   fetch_entry_o.rdata, exp_addr, instr_word(exp_addr));
        end
        if (fetch_entry_o.err !== (exp_addr == err_addr)) begin
          errors++;
          $display("Fail at %0t: err %b at %h", $time, fetch_entry_o.err, exp_addr);
        end
        if (fetch_entry_o.err) err_seen++;
        exp_addr = exp_addr + 32'd4;
        accepted++;
        live_accepts++;
      end
      if (instr_req_o && instr_gnt_i) begin
        in_flight++;
        if (instr_addr_o >= stream_base && instr_addr_o < stream_base + 32'h1000) live_grants++;
      end
      if (instr_rvalid_i) in_flight--;
      // Granted but not yet taken must fit the FIFO
      if (live_grants - live_accepts > fifo_depth_lp) begin
        errors++;
        $display("Fail at %0t: %0d words granted ahead, limit %0d", $time,
                 live_grants - live_accepts, fifo_depth_lp);
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int          n;
    logic [31:0] err_target;
    clk = 1'b0;
    rst_n_i = 1'b0;
    req_i = 1'b0;
    branch_i = 1'b0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b1;
    lfsr_q = 32'h2a1e3b3f;
    mem_rand = '0;
    ready_rand_en = 1'b0;
    err_addr = 32'hffff_fffc;  // Outside every stream
    exp_addr = '0;
    stream_base = '0;
    accepted = 0;
    live_grants = 0;
    live_accepts = 0;
    in_flight = 0;
    err_seen = 0;
    checks = 0;
    errors = 0;
    tests = 0;
    timed_out = 1'b0;
    repeat (5) @(posedge clk);
    rst_n_i <= 1'b1;

    @(negedge clk);
    checks++;
    if (fetch_valid_o !== 1'b0 || instr_req_o !== 1'b0 || busy_o !== 1'b0) begin
      errors++;
      $display("Fail at %0t: outputs not idle after reset", $time);
    end
    finish_test("reset state");

    // Start the stream with a branch from idle
    @(posedge clk);
    req_i         <= 1'b1;
    branch_i      <= 1'b1;
    branch_addr_i <= 32'h0000_0100;
    @(posedge clk);
    branch_i <= 1'b0;
    wait_accepts(16, 400, "sequential fetch");
    finish_test("sequential fetch");

    @(posedge clk);
    ready_rand_en <= 1'b1;
    wait_accepts(24, 1000, "back-pressure");
    finish_test("back-pressure");

    // Branch only once something is in flight
    n = 0;
    @(negedge clk);
    while (in_flight == 0 && n < 200 && !timed_out) begin
      @(negedge clk);
      n++;
    end
    if (in_flight == 0 && !timed_out) begin
      timed_out = 1'b1;
      $display("Timeout: no request in flight before the branch");
    end
    @(posedge clk);
    branch_i      <= 1'b1;
    branch_addr_i <= 32'h0000_4006;  // Lands on 0x4004
    @(posedge clk);
    branch_i <= 1'b0;
    wait_accepts(12, 600, "branch");
    finish_test("branch with stale responses");

    @(negedge clk);
    err_target = exp_addr + 32'd24;  // Beyond anything already granted
    @(posedge clk);
    err_addr <= err_target;
    wait_accepts(10, 600, "bus error");
    checks++;
    if (err_seen != 1 && !timed_out) begin
      errors++;
      $display("Fail at %0t: %0d words with err, expected 1", $time, err_seen);
    end
    finish_test("bus error");

    @(posedge clk);
    req_i         <= 1'b0;
    ready_rand_en <= 1'b0;
    n = 0;
    @(negedge clk);
    while (busy_o && n < 200 && !timed_out) begin
      @(negedge clk);
      n++;
    end
    if (busy_o && !timed_out) begin
      timed_out = 1'b1;
      $display("Timeout: busy_o still high after req_i dropped");
    end
    checks++;
    if (in_flight != 0 && !timed_out) begin
      errors++;
      $display("Fail at %0t: busy_o low with %0d responses missing", $time, in_flight);
    end
    finish_test("idle");

    errors = errors + int'(u_dut.u_props.fail_count);
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d words taken%s",
             tests, checks, errors, accepted, timed_out ? ", run timed out" : "");
    if (errors == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
